// File: Bender.yml
package:
  name: fq_handler

sources:
  - fq_pkg.sv
  - fq_event_fifo.sv
  - fq_record_builder.sv
  - fq_queue_ctrl.sv
  - fq_axi_writer.sv
  - fq_handler.sv
  - target: test
    files:
      - tb_fq_mem_slave.sv
      - tb_fq_handler.sv

// File: all.f
fq_pkg.sv
fq_event_fifo.sv
fq_record_builder.sv
fq_queue_ctrl.sv
fq_axi_writer.sv
fq_handler.sv
tb_fq_mem_slave.sv
tb_fq_handler.sv

// File: fq_axi_writer.sv
// AXI4 write master that sends one fault record as a four-beat burst
`timescale 1ns/1ps
`default_nettype none

module fq_axi_writer (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       start_i,
    input  wire logic [fq_pkg::PADDR_W-1:0] addr_i,
    input  wire fq_pkg::fq_record_t         rec_i,
    output logic                            done_o,     // B handshake
    output logic                            err_o,
    output fq_pkg::axi_w_req_t              mem_req_o,
    input  wire fq_pkg::axi_w_rsp_t         mem_rsp_i
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_AW,
        WR_W,
        WR_B
    } wr_state_e;

    wr_state_e                  state_q, state_d;
    logic [1:0]                 beat_q, beat_d;
    logic [fq_pkg::PADDR_W-1:0] addr_q;
    logic [255:0]               rec_bits;

    assign rec_bits = rec_i;
    assign err_o    = (mem_rsp_i.b_resp != fq_pkg::RESP_OKAY);

    always_comb begin
        state_d = state_q;
        beat_d  = beat_q;
        done_o  = 1'b0;

        mem_req_o          = '0;
        mem_req_o.aw_addr  = addr_q;
        mem_req_o.aw_len   = 8'(fq_pkg::BEATS - 1);
        mem_req_o.w_data   = rec_bits[{beat_q, 6'd0} +: 64];   // Low slice first
        mem_req_o.w_last   = (beat_q == 2'(fq_pkg::BEATS - 1));

        case (state_q)
            WR_IDLE: begin
                if (start_i) begin
                    state_d = WR_AW;
                end
            end

            WR_AW: begin
                mem_req_o.aw_valid = 1'b1;
                if (mem_rsp_i.aw_ready) begin
                    beat_d  = '0;
                    state_d = WR_W;
                end
            end

            WR_W: begin
                mem_req_o.w_valid = 1'b1;
                if (mem_rsp_i.w_ready) begin
                    beat_d = beat_q + 1'b1;     // Only on an accepted beat
                    if (mem_req_o.w_last) begin
                        state_d = WR_B;
                    end
                end
            end

            WR_B: begin
                // Ready raised only alongside a valid response
                mem_req_o.b_ready = mem_rsp_i.b_valid;
                if (mem_rsp_i.b_valid) begin
                    done_o  = 1'b1;
                    state_d = WR_IDLE;
                end
            end

            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (start_i && state_q == WR_IDLE) begin
            addr_q <= addr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
        end
    end

endmodule

`default_nettype wire

// File: fq_event_fifo.sv
// Fall-through event buffer in front of the queue controller, payload type set by the parent
`timescale 1ns/1ps
`default_nettype none

module fq_event_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type         data_t = logic [7:0]
) (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    input  wire logic  push_i,
    input  wire data_t data_i,
    input  wire logic  pop_i,
    output data_t      data_o,
    output logic       valid_o,     // Not empty, or an item passing through
    output logic       full_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    data_t             mem_q [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              empty;
    logic              store;       // Item goes into the array
    logic              take;        // Head item leaves the array

    assign empty   = (cnt_q == '0);
    assign full_o  = (cnt_q == CNT_W'(DEPTH));
    assign valid_o = !empty || push_i;
    assign data_o  = empty ? data_i : mem_q[rd_ptr_q];  // Bypass when empty

    // A push that is popped at once while empty never touches the array
    assign store = push_i && !full_o && !(empty && pop_i);
    assign take  = pop_i && !empty;

    always_ff @(posedge clk_i) begin
        if (store) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (store) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (take) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Count moves only when exactly one side changes it
            if (store && !take) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (take && !store) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: fq_handler.sv
// Top level of the IOMMU fault-queue writer, connects buffer, formatter, control and AXI side
`timescale 1ns/1ps
`default_nettype none

module fq_handler #(
    parameter int unsigned EVT_DEPTH = 4
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    // Fault events
    input  wire logic                       event_valid_i,
    input  wire fq_pkg::fq_event_t          event_i,
    // Register map
    input  wire logic [fq_pkg::PPN_W-1:0]   base_ppn_i,
    input  wire logic [4:0]                 size_i,
    input  wire logic                       en_i,
    input  wire logic                       ie_i,
    input  wire logic [31:0]                head_i,
    input  wire logic [31:0]                tail_i,
    input  wire logic                       mf_i,
    input  wire logic                       of_i,
    output logic [31:0]                     tail_o,
    output logic                            tail_we_o,
    output logic                            mf_o,
    output logic                            of_o,
    output logic                            err_we_o,
    output logic                            fq_on_o,
    output logic                            busy_o,
    output logic                            ip_o,
    output logic                            full_o,     // Event buffer full
    // Memory
    output fq_pkg::axi_w_req_t              mem_req_o,
    input  wire fq_pkg::axi_w_rsp_t         mem_rsp_i
);

    logic                       evt_valid;
    fq_pkg::fq_event_t          evt;
    logic                       evt_pop;
    logic                       wr_start;
    logic [fq_pkg::PADDR_W-1:0] wr_addr;
    logic                       wr_done;
    logic                       wr_err;
    fq_pkg::fq_record_t         rec;

    fq_event_fifo #(
        .DEPTH  (EVT_DEPTH),
        .data_t (fq_pkg::fq_event_t)
    ) i_event_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (event_valid_i),
        .data_i  (event_i),
        .pop_i   (evt_pop),
        .data_o  (evt),
        .valid_o (evt_valid),
        .full_o  (full_o)
    );

    fq_record_builder i_record_builder (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .load_i (wr_start),
        .evt_i  (evt),
        .rec_o  (rec)
    );

    fq_queue_ctrl i_queue_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .base_ppn_i  (base_ppn_i),
        .size_i      (size_i),
        .en_i        (en_i),
        .ie_i        (ie_i),
        .head_i      (head_i),
        .tail_i      (tail_i),
        .mf_i        (mf_i),
        .of_i        (of_i),
        .evt_valid_i (evt_valid),
        .evt_pop_o   (evt_pop),
        .wr_start_o  (wr_start),
        .wr_addr_o   (wr_addr),
        .wr_done_i   (wr_done),
        .wr_err_i    (wr_err),
        .tail_o      (tail_o),
        .tail_we_o   (tail_we_o),
        .mf_o        (mf_o),
        .of_o        (of_o),
        .err_we_o    (err_we_o),
        .ip_o        (ip_o),
        .fq_on_o     (fq_on_o),
        .busy_o      (busy_o)
    );

    fq_axi_writer i_axi_writer (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .start_i   (wr_start),
        .addr_i    (wr_addr),
        .rec_i     (rec),
        .done_o    (wr_done),
        .err_o     (wr_err),
        .mem_req_o (mem_req_o),
        .mem_rsp_i (mem_rsp_i)
    );

endmodule

`default_nettype wire

// File: fq_pkg.sv
// Shared widths, fault event and record layouts and AXI write bundles for the fault-queue writer
`default_nettype none

package fq_pkg;

    // Address and field widths
    localparam int unsigned PPN_W   = 44;   // Physical page number
    localparam int unsigned PADDR_W = 56;   // Physical address
    localparam int unsigned IOVA_W  = 64;
    localparam int unsigned GPA_W   = 41;   // GPA bits [63:2] as reported
    localparam int unsigned TTYP_W  = 6;
    localparam int unsigned CAUSE_W = 12;
    localparam int unsigned DID_W   = 24;   // Device ID
    localparam int unsigned PID_W   = 20;   // Process ID

    // Transaction types with special formatting
    localparam logic [TTYP_W-1:0] TTYP_NONE     = 6'd0;
    localparam logic [TTYP_W-1:0] TTYP_PCIE_MSG = 6'd9;

    localparam int unsigned BEATS     = 4;      // 64-bit beats per 32-byte record
    localparam logic [1:0]  RESP_OKAY = 2'b00;

    // One fault event as captured from the translation logic
    typedef struct packed {
        logic [TTYP_W-1:0]  ttyp;
        logic [CAUSE_W-1:0] cause;
        logic [IOVA_W-1:0]  iova;
        logic [GPA_W-1:0]   gpa;
        logic [DID_W-1:0]   did;
        logic               pv;             // PID valid
        logic [PID_W-1:0]   pid;
        logic               is_supervisor;
        logic               is_guest_pf;
        logic               is_implicit;    // Guest fault from an implicit access
    } fq_event_t;

    // Fault queue record, cause sits in the low bits of beat 0
    typedef struct packed {
        logic [IOVA_W-1:0]  iotval2;        // Beat 3
        logic [IOVA_W-1:0]  iotval;         // Beat 2
        logic [63:0]        reserved;       // Beat 1
        logic [PID_W-1:0]   pid;
        logic               pv;
        logic               priv;
        logic [TTYP_W-1:0]  ttyp;
        logic [DID_W-1:0]   did;
        logic [CAUSE_W-1:0] cause;
    } fq_record_t;

    // Write-only AXI4 request side
    typedef struct packed {
        logic               aw_valid;
        logic [PADDR_W-1:0] aw_addr;
        logic [7:0]         aw_len;         // Beats minus one
        logic               w_valid;
        logic [63:0]        w_data;
        logic               w_last;
        logic               b_ready;
    } axi_w_req_t;

    // Write-only AXI4 response side
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        logic [1:0] b_resp;
    } axi_w_rsp_t;

endpackage

`default_nettype wire

// File: fq_queue_ctrl.sv
// Fault queue control: enable tracking, full check, entry address, tail and error updates
`timescale 1ns/1ps
`default_nettype none

module fq_queue_ctrl (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic [fq_pkg::PPN_W-1:0]   base_ppn_i,
    input  wire logic [4:0]                 size_i,     // log2(entries) - 1
    input  wire logic                       en_i,
    input  wire logic                       ie_i,
    input  wire logic [31:0]                head_i,
    input  wire logic [31:0]                tail_i,
    input  wire logic                       mf_i,
    input  wire logic                       of_i,
    input  wire logic                       evt_valid_i,
    output logic                            evt_pop_o,
    output logic                            wr_start_o,
    output logic [fq_pkg::PADDR_W-1:0]      wr_addr_o,
    input  wire logic                       wr_done_i,
    input  wire logic                       wr_err_i,   // Non-OKAY write response
    output logic [31:0]                     tail_o,
    output logic                            tail_we_o,
    output logic                            mf_o,
    output logic                            of_o,
    output logic                            err_we_o,
    output logic                            ip_o,
    output logic                            fq_on_o,
    output logic                            busy_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_ERROR
    } state_e;

    state_e      state_q, state_d;
    logic        en_q, en_d;        // Enable as seen by the queue
    logic        en_rise;
    logic [31:0] idx_mask;
    logic [31:0] tail_m, head_m;
    logic [31:0] tail_inc;          // Next tail, already wrapped
    logic        q_full;

    // Index width is size+1 bits, never below 7
    assign idx_mask = (size_i < 5'd6) ? 32'h0000_007F
                                      : ~({32{1'b1}} << ({1'b0, size_i} + 6'd1));
    assign tail_m   = tail_i & idx_mask;
    assign head_m   = head_i & idx_mask;
    assign tail_inc = (tail_i + 32'd1) & idx_mask;
    assign q_full   = (tail_inc == head_m);     // One slot kept free

    // Base page plus 32-byte entry offset
    assign wr_addr_o = {base_ppn_i, 12'b0}
                     | {{(fq_pkg::PADDR_W - 37){1'b0}}, tail_m, 5'b0};

    assign en_rise = en_i & ~en_q;
    assign busy_o  = en_i ^ en_q;   // Transition in progress
    assign fq_on_o = en_q | en_i;

    always_comb begin
        state_d    = state_q;
        en_d       = en_i;
        evt_pop_o  = 1'b0;
        wr_start_o = 1'b0;
        tail_o     = tail_i;
        tail_we_o  = 1'b0;
        mf_o       = mf_i;
        of_o       = of_i;
        err_we_o   = 1'b0;
        ip_o       = 1'b0;

        // Keep the queue on until an in-flight record is written
        if (state_q == ST_WRITE && !en_i) begin
            en_d = en_q;
        end

        // Fresh enable clears tail and both error bits
        if (en_rise) begin
            tail_o    = '0;
            tail_we_o = 1'b1;
            mf_o      = 1'b0;
            of_o      = 1'b0;
            err_we_o  = 1'b1;
        end

        case (state_q)
            ST_IDLE: begin
                if (evt_valid_i && !en_i) begin
                    evt_pop_o = 1'b1;               // Queue off, fault discarded
                end else if (evt_valid_i && en_q) begin
                    evt_pop_o = 1'b1;
                    if (q_full) begin
                        of_o     = 1'b1;            // Record lost
                        err_we_o = 1'b1;
                        ip_o     = ie_i;
                        state_d  = ST_ERROR;
                    end else begin
                        wr_start_o = 1'b1;
                        state_d    = ST_WRITE;
                    end
                end
            end

            ST_WRITE: begin
                if (wr_done_i) begin
                    ip_o = ie_i;
                    if (wr_err_i) begin
                        mf_o     = 1'b1;
                        err_we_o = 1'b1;
                        state_d  = ST_ERROR;
                    end else begin
                        tail_o    = tail_inc;
                        tail_we_o = 1'b1;
                        state_d   = ST_IDLE;
                    end
                end
            end

            ST_ERROR: begin
                // Stay until software clears both error bits
                if (!mf_i && !of_i) begin
                    state_d = ST_IDLE;
                end
            end

            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            en_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            en_q    <= en_d;
        end
    end

endmodule

`default_nettype wire

// File: fq_record_builder.sv
// Formats a fault event into a 32-byte queue record and holds it while the burst runs
`timescale 1ns/1ps
`default_nettype none

module fq_record_builder (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire logic               load_i,     // Same pulse that starts the write
    input  wire fq_pkg::fq_event_t  evt_i,
    output fq_pkg::fq_record_t      rec_o
);

    fq_pkg::fq_record_t rec_d, rec_q;

    always_comb begin
        rec_d       = '0;
        rec_d.cause = evt_i.cause;
        rec_d.ttyp  = evt_i.ttyp;

        // Requester fields are only meaningful with a real transaction
        if (evt_i.ttyp != fq_pkg::TTYP_NONE) begin
            rec_d.did  = evt_i.did;
            rec_d.pv   = evt_i.pv;
            rec_d.pid  = evt_i.pv ? evt_i.pid : '0;
            rec_d.priv = evt_i.pv & evt_i.is_supervisor;
        end

        // PCIe messages carry no address
        if (evt_i.ttyp != fq_pkg::TTYP_PCIE_MSG) begin
            rec_d.iotval = evt_i.iova;
        end

        // Guest page fault reports GPA[63:2] in place
        if (evt_i.is_guest_pf) begin
            rec_d.iotval2    = fq_pkg::IOVA_W'(evt_i.gpa) << 2;
            rec_d.iotval2[0] = evt_i.is_implicit;   // Implicit first-stage access
            rec_d.iotval2[1] = 1'b0;                // No A/D update support
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rec_q <= '0;
        end else if (load_i) begin
            rec_q <= rec_d;
        end
    end

    assign rec_o = rec_q;

endmodule

`default_nettype wire

// File: tb_fq_handler.sv
// Testbench for the fault-queue writer, random events against a register map model and a reference
`timescale 1ns/1ps
`default_nettype none

module tb_fq_handler;

    localparam int TIMEOUT   = 40 * 60;  // 40 events, 60 cycles each
    localparam int EVT_DEPTH = 4;        // Event buffer entries

    logic                       clk_i;
    logic                       rst_ni;
    logic                       event_valid;
    fq_pkg::fq_event_t          event_d;
    logic [fq_pkg::PPN_W-1:0]   base_ppn;
    logic [4:0]                 size;
    logic                       en, ie;
    logic [31:0]                reg_head, reg_tail;    // Register map model
    logic                       reg_mf, reg_of;
    logic [31:0]                tail_o;
    logic                       tail_we_o, mf_o, of_o, err_we_o;
    logic                       fq_on_o, busy_o, ip_o, full_o;
    fq_pkg::axi_w_req_t         mem_req;
    fq_pkg::axi_w_rsp_t         mem_rsp;
    logic [2:0]                 aw_wait, w_wait, b_wait;
    logic                       err_resp;
    int                         bursts, proto_errs;
    logic [fq_pkg::PADDR_W-1:0] wr_addr;
    logic [255:0]               wr_data;
    int                         errors, cycles, done_cnt, ip_cnt, busy_cnt;
    logic                       en_prev;
    logic [31:0]                lfsr;

    fq_handler #(
        .EVT_DEPTH (EVT_DEPTH)
    ) fq_handler_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .event_valid_i (event_valid),
        .event_i       (event_d),
        .base_ppn_i    (base_ppn),
        .size_i        (size),
        .en_i          (en),
        .ie_i          (ie),
        .head_i        (reg_head),
        .tail_i        (reg_tail),
        .mf_i          (reg_mf),
        .of_i          (reg_of),
        .tail_o        (tail_o),
        .tail_we_o     (tail_we_o),
        .mf_o          (mf_o),
        .of_o          (of_o),
        .err_we_o      (err_we_o),
        .fq_on_o       (fq_on_o),
        .busy_o        (busy_o),
        .ip_o          (ip_o),
        .full_o        (full_o),
        .mem_req_o     (mem_req),
        .mem_rsp_i     (mem_rsp)
    );

    tb_fq_mem_slave i_mem (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (mem_req),
        .rsp_o        (mem_rsp),
        .aw_wait_i    (aw_wait),
        .w_wait_i     (w_wait),
        .b_wait_i     (b_wait),
        .err_resp_i   (err_resp),
        .bursts_o     (bursts),
        .addr_o       (wr_addr),
        .data_o       (wr_data),
        .proto_errs_o (proto_errs)
    );

    always #10 clk_i = ~clk_i;

    // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] index_mask(input logic [4:0] sz);
        int w;
        w = (sz + 1 < 7) ? 7 : sz + 1;     // At least 128 entries
        return 32'((64'd1 << w) - 1);
    endfunction

    function automatic fq_pkg::fq_event_t random_event();
        fq_pkg::fq_event_t ev;
        logic [1:0]        kind;
        kind             = rand_bits(2);
        ev.ttyp          = (kind == 2'd0) ? fq_pkg::TTYP_NONE :
                           (kind == 2'd1) ? fq_pkg::TTYP_PCIE_MSG : rand_bits(6);
        ev.cause         = rand_bits(12);
        ev.iova          = rand_bits(64);
        ev.gpa           = rand_bits(41);
        ev.did           = rand_bits(24);
        ev.pv            = rand_bits(1);
        ev.pid           = rand_bits(20);
        ev.is_supervisor = rand_bits(1);
        ev.is_guest_pf   = rand_bits(1);
        ev.is_implicit   = rand_bits(1);
        return ev;
    endfunction

    // Expected record straight from the formatting rules
    function automatic fq_pkg::fq_record_t model_record(input fq_pkg::fq_event_t ev);
        fq_pkg::fq_record_t r;
        logic               txn;
        r       = '0;
        txn     = (ev.ttyp != fq_pkg::TTYP_NONE);
        r.cause = ev.cause;
        r.ttyp  = ev.ttyp;
        r.did   = txn ? ev.did : '0;
        r.pv    = txn & ev.pv;
        r.pid   = (txn && ev.pv) ? ev.pid : '0;
        r.priv  = txn & ev.pv & ev.is_supervisor;
        r.iotval  = (ev.ttyp == fq_pkg::TTYP_PCIE_MSG) ? '0 : ev.iova;
        r.iotval2 = ev.is_guest_pf ? {21'b0, ev.gpa, 1'b0, ev.is_implicit} : '0;
        return r;
    endfunction

    task automatic report_mismatch(input string what, input logic [255:0] got,
                                   input logic [255:0] exp);
        $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
        errors++;
    endtask

    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    task automatic push_event(input fq_pkg::fq_event_t ev);
        event_d     = ev;
        event_valid = 1'b1;
        step();
        event_valid = 1'b0;
    endtask

    // One event that ends in a burst, OKAY or error response
    task automatic expect_write(input fq_pkg::fq_event_t ev, input logic err, input logic push);
        fq_pkg::fq_record_t         exp_rec;
        logic [fq_pkg::PADDR_W-1:0] exp_addr;
        logic [31:0]                mask, old_tail;
        int                         b0, ip0, d0;
        exp_rec  = model_record(ev);
        mask     = index_mask(size);
        exp_addr = {base_ppn, 12'b0} | (fq_pkg::PADDR_W'(reg_tail & mask) << 5);
        old_tail = reg_tail;
        b0       = bursts;
        ip0      = ip_cnt;
        d0       = done_cnt;
        if (push) begin
            push_event(ev);
        end
        while (done_cnt == d0) step();
        if (bursts != b0 + 1) begin
            $display("Error at %0t: event finished without exactly one burst", $time);
            errors++;
        end
        if (wr_addr != exp_addr) report_mismatch("entry address", wr_addr, exp_addr);
        if (wr_data != exp_rec) report_mismatch("record", wr_data, exp_rec);
        if (ip_cnt != ip0 + ie) report_mismatch("ip pulses", ip_cnt - ip0, ie);
        if (err) begin
            if (reg_mf !== 1'b1) report_mismatch("mf after error response", reg_mf, 1'b1);
            if (reg_tail != old_tail) report_mismatch("tail after error", reg_tail, old_tail);
        end else begin
            if (reg_tail != ((old_tail + 1) & mask)) begin
                report_mismatch("tail", reg_tail, (old_tail + 1) & mask);
            end
        end
    endtask

    task automatic check_overflow();
        fq_pkg::fq_event_t ev1;
        fq_pkg::fq_event_t held [EVT_DEPTH];
        logic [31:0]       mask, old_tail;
        int                b0, ip0, d0;
        mask     = index_mask(size);
        reg_head = (reg_tail + 1) & mask;   // No free slot
        ie       = 1'b1;
        ev1      = random_event();
        for (int k = 0; k < EVT_DEPTH; k++) begin
            held[k] = random_event();
        end
        old_tail = reg_tail;
        b0       = bursts;
        ip0      = ip_cnt;
        d0       = done_cnt;
        push_event(ev1);
        while (done_cnt == d0) step();
        if (reg_of !== 1'b1) report_mismatch("of on full queue", reg_of, 1'b1);
        if (reg_tail != old_tail) report_mismatch("tail on full queue", reg_tail, old_tail);
        if (ip_cnt != ip0 + 1) report_mismatch("ip on overflow", ip_cnt - ip0, 1);
        // Events wait in the buffer while of stays set
        for (int k = 0; k < EVT_DEPTH; k++) begin
            push_event(held[k]);
            if (full_o !== (k == EVT_DEPTH - 1)) begin
                report_mismatch("event buffer full", full_o, k == EVT_DEPTH - 1);
            end
        end
        repeat (12) step();
        if (bursts != b0 || done_cnt != d0 + 1) begin
            $display("Error at %0t: queue written while overflow was pending", $time);
            errors++;
        end
        reg_head = (reg_tail + 9) & mask;
        reg_of   = 1'b0;
        for (int k = 0; k < EVT_DEPTH; k++) begin
            expect_write(held[k], 1'b0, 1'b0);  // Held events go out in order after the clear
        end
    endtask

    // Register map and pulse counters, sampled at the edge
    always @(posedge clk_i) begin
        if (rst_ni) begin
            cycles++;
            if (busy_o) busy_cnt++;
            if (ip_o) ip_cnt++;
            if ((tail_we_o || err_we_o) && !busy_o) done_cnt++;
            if (fq_on_o !== (en | en_prev)) report_mismatch("fq_on", fq_on_o, en | en_prev);
            en_prev = en;
            if (tail_we_o) reg_tail <= tail_o;
            if (err_we_o) begin
                reg_mf <= mf_o;
                reg_of <= of_o;
            end
            if (cycles > TIMEOUT) begin
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    initial begin
        fq_pkg::fq_event_t ev;
        int                b0;
        lfsr        = 32'd41;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        event_valid = 1'b0;
        event_d     = '0;
        base_ppn    = rand_bits(44);
        size        = 5'd0;
        en          = 1'b0;
        ie          = 1'b0;
        reg_head    = '0;
        reg_tail    = 32'd5;    // Stale values the enable must clear
        reg_mf      = 1'b1;
        reg_of      = 1'b1;
        aw_wait     = '0;
        w_wait      = '0;
        b_wait      = '0;
        err_resp    = 1'b0;
        errors      = 0;
        cycles      = 0;
        done_cnt    = 0;
        ip_cnt      = 0;
        busy_cnt    = 0;
        en_prev     = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        step();

        // Enable edge
        b0 = busy_cnt;
        en = 1'b1;
        repeat (3) step();
        if (busy_cnt != b0 + 1) report_mismatch("busy cycles on enable", busy_cnt - b0, 1);
        if (reg_tail != 0) report_mismatch("tail after enable", reg_tail, 0);
        if (reg_mf !== 1'b0 || reg_of !== 1'b0) report_mismatch("mf/of after enable",
                                                                {reg_mf, reg_of}, 0);

        reg_tail = 32'd124;     // Start near the end to cross the wrap
        for (int i = 0; i < 30; i++) begin
            ev       = random_event();
            aw_wait  = rand_bits(3);
            w_wait   = rand_bits(3);
            b_wait   = rand_bits(3);
            ie       = rand_bits(1);
            err_resp = (i % 10 == 6);
            reg_head = (reg_tail + 2 + 32'(rand_bits(4))) & index_mask(size);
            expect_write(ev, err_resp, 1'b1);
            if (err_resp) begin
                reg_mf = 1'b0;  // Software clears the fault
            end
        end
        err_resp = 1'b0;
        check_overflow();

        // Disable edge
        b0 = busy_cnt;
        en = 1'b0;
        repeat (3) step();
        if (busy_cnt != b0 + 1) report_mismatch("busy cycles on disable", busy_cnt - b0, 1);
        if (fq_on_o !== 1'b0) report_mismatch("fq_on after disable", fq_on_o, 0);

        $display("Closing count: %0d check errors, %0d protocol errors", errors, proto_errs);
        if (errors == 0 && proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_fq_mem_slave.sv
// Testbench AXI4 write slave for the fault queue, with ready delays set per burst and an error response
`timescale 1ns/1ps
`default_nettype none

module tb_fq_mem_slave (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire fq_pkg::axi_w_req_t         req_i,
    output fq_pkg::axi_w_rsp_t              rsp_o,
    input  wire logic [2:0]                 aw_wait_i,  // Cycles of aw_valid before aw_ready
    input  wire logic [2:0]                 w_wait_i,   // Idle cycles before each beat
    input  wire logic [2:0]                 b_wait_i,
    input  wire logic                       err_resp_i, // Answer SLVERR
    output int                              bursts_o,   // Completed W bursts
    output logic [fq_pkg::PADDR_W-1:0]      addr_o,     // Address of the last burst
    output logic [255:0]                    data_o,     // Four beats of the last burst
    output int                              proto_errs_o
);

    typedef enum logic [1:0] {
        PH_AW,
        PH_W,
        PH_B
    } phase_e;

    phase_e       phase;
    int           wait_cnt;     // Cycles spent in the current phase
    int           beat;
    logic [255:0] data_acc;

    initial begin
        rsp_o        = '0;
        bursts_o     = 0;
        proto_errs_o = 0;
        addr_o       = '0;
        data_o       = '0;
        phase        = PH_AW;
        wait_cnt     = 0;
        beat         = 0;
        data_acc     = '0;
    end

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            phase    = PH_AW;
            wait_cnt = 0;
            beat     = 0;
        end else begin
            case (phase)
                PH_AW: begin
                    if (req_i.aw_valid && rsp_o.aw_ready) begin
                        if (req_i.aw_len != 8'(fq_pkg::BEATS - 1)) begin
                            $display("Protocol error at %0t: burst of %0d beats instead of four",
                                     $time, req_i.aw_len + 1);
                            proto_errs_o++;
                        end
                        addr_o  <= req_i.aw_addr;
                        phase    = PH_W;
                        wait_cnt = 0;
                        beat     = 0;
                    end else if (req_i.aw_valid) begin
                        wait_cnt++;     // Delay counts from the request
                    end
                end

                PH_W: begin
                    if (req_i.w_valid && rsp_o.w_ready) begin
                        if (req_i.w_last != (beat == fq_pkg::BEATS - 1)) begin
                            $display("Protocol error at %0t: w_last wrong on beat %0d", $time, beat);
                            proto_errs_o++;
                        end
                        data_acc[beat*64 +: 64] = req_i.w_data;
                        beat++;
                        wait_cnt = 0;
                        if (beat == fq_pkg::BEATS) begin
                            data_o   <= data_acc;
                            bursts_o <= bursts_o + 1;
                            phase     = PH_B;
                        end
                    end else begin
                        wait_cnt++;
                    end
                end

                PH_B: begin
                    if (rsp_o.b_valid && req_i.b_ready) begin
                        phase    = PH_AW;
                        wait_cnt = 0;
                    end else begin
                        wait_cnt++;
                    end
                end

                default: phase = PH_AW;
            endcase
        end
        // Responses change a little after the edge
        #2;
        rsp_o.aw_ready = (phase == PH_AW) && (wait_cnt >= aw_wait_i);
        rsp_o.w_ready  = (phase == PH_W) && (wait_cnt >= w_wait_i);
        rsp_o.b_valid  = (phase == PH_B) && (wait_cnt >= b_wait_i);    // Held until b_ready
        rsp_o.b_resp   = err_resp_i ? 2'b10 : fq_pkg::RESP_OKAY;
    end

endmodule

`default_nettype wire
